//--- Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- alu/alu.sv
`timescale 1ns/1ps

module alu
  import coreDefs::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  aluOp                 op,
  input  logic                 carryIn,
  output logic [dataWidth-1:0] result,
  output logic [3:0]           flagsOut
);

  logic [dataWidth-1:0] addX;
  logic [dataWidth-1:0] addY;
  logic                 addCin;
  logic [dataWidth:0]   sum;
  logic                 isArith;
  logic                 carry;
  logic                 overflow;

  // Adder operands; subtraction is x + ~y + 1, so carry means no borrow
  always_comb
  begin
    addX = a;
    addY = b;
    addCin = 1'b0;
    isArith = 1'b1;
    case (op)
      opSub, opCmp:
      begin
        addY = ~b;
        addCin = 1'b1;
      end
      opRsb:
      begin
        addX = b;
        addY = ~a;
        addCin = 1'b1;
      end
      opAdd, opCmn:
      begin
        addCin = 1'b0;
      end
      opAdc:
      begin
        addCin = carryIn;
      end
      opSbc:
      begin
        addY = ~b;
        addCin = carryIn;
      end
      opRsc:
      begin
        addX = b;
        addY = ~a;
        addCin = carryIn;
      end
      default:
      begin
        isArith = 1'b0;
      end
    endcase
  end

  assign sum = {1'b0, addX} + {1'b0, addY} + {{dataWidth{1'b0}}, addCin};

  always_comb
  begin
    case (op)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opOrr:        result = a | b;
      opMov:        result = b;
      opBic:        result = a & ~b;
      opMvn:        result = ~b;
      default:      result = sum[dataWidth-1:0];
    endcase
  end

  // Signs agree going in, differ coming out
  assign overflow = (addX[dataWidth-1] == addY[dataWidth-1]) &&
                    (sum[dataWidth-1] != addX[dataWidth-1]);

  // Logical ops keep the old carry
  assign carry = isArith ? sum[dataWidth] : carryIn;

  assign flagsOut = {result[dataWidth-1], result == '0, carry, isArith & overflow};

endmodule

//--- common/coreDefs.sv
package coreDefs;

  localparam int dataWidth = 32;
  localparam int regIndexWidth = 4;
  localparam int regCount = 16;

  // ARM data-processing opcodes in encoding order
  typedef enum logic [3:0] {
    opAnd,
    opEor,
    opSub,
    opRsb,
    opAdd,
    opAdc,
    opSbc,
    opRsc,
    opTst,
    opTeq,
    opCmp,
    opCmn,
    opOrr,
    opMov,
    opBic,
    opMvn
  } aluOp;

  typedef enum logic [1:0] {
    idle,
    decode,
    execute,
    writeBack
  } seqState;

  // Instruction fields
  localparam int classHi = 27;
  localparam int classLo = 25;
  localparam int opHi = 24;
  localparam int opLo = 21;
  localparam int setFlagsBit = 20;
  localparam int rnHi = 19;
  localparam int rnLo = 16;
  localparam int rdHi = 15;
  localparam int rdLo = 12;
  localparam int rotHi = 11;
  localparam int rotLo = 8;
  localparam int immHi = 7;
  localparam int immLo = 0;

  // Data processing with rotated immediate
  localparam logic [2:0] immClass = 3'b001;

  // APB register map
  localparam logic [31:0] instrAddr = 32'h00;
  // Bit 0 busy, bit 1 illegal, bits 31:28 NZCV
  localparam logic [31:0] statusAddr = 32'h04;
  localparam logic [31:0] regBaseAddr = 32'h40;

endpackage

//--- registerFile/registerFile.sv
`timescale 1ns/1ps

module registerFile
  import coreDefs::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     writeEnable,
  input  logic [regIndexWidth-1:0] writeIndex,
  input  logic [regIndexWidth-1:0] readIndexN,
  input  logic [regIndexWidth-1:0] debugIndex,
  input  logic [dataWidth-1:0]     writeData,
  output logic [dataWidth-1:0]     readDataN,
  output logic [dataWidth-1:0]     debugData
);

  logic [dataWidth-1:0] regs [regCount];
  logic [regCount-1:0]  writeSelect;

  // One-hot write decode
  always_comb
  begin
    writeSelect = '0;
    if (writeEnable)
      writeSelect[writeIndex] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < regCount; i++)
    begin
      if (reset)
        regs[i] <= '0;
      else if (writeSelect[i])
        regs[i] <= writeData;
    end
  end

  // Operand and debug read ports
  assign readDataN = regs[readIndexN];
  assign debugData = regs[debugIndex];

endmodule

//--- source/apbHostPort.sv
`timescale 1ns/1ps

module apbHostPort
  import coreDefs::*;
#(
  parameter int apbAddrWidth = 8
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [apbAddrWidth-1:0]  paddr,
  input  logic [dataWidth-1:0]     pwdata,
  input  logic                     busy,
  input  logic                     illegal,
  input  logic [3:0]               flags,
  input  logic [dataWidth-1:0]     debugData,
  output logic [dataWidth-1:0]     prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [dataWidth-1:0]     instr,
  output logic                     start,
  output logic [regIndexWidth-1:0] debugIndex
);

  logic isInstr;
  logic isStatus;
  logic isReg;
  logic mapped;
  logic access;
  logic hold;
  logic [dataWidth-1:0] status;

  // Address decode
  assign isInstr = (paddr == apbAddrWidth'(instrAddr));
  assign isStatus = (paddr == apbAddrWidth'(statusAddr));
  assign isReg = (paddr[apbAddrWidth-1:regIndexWidth+2] ==
                  regBaseAddr[apbAddrWidth-1:regIndexWidth+2]) &&
                 (paddr[1:0] == 2'b00);
  assign mapped = isInstr || isStatus || isReg;

  assign access = psel && penable;

  // Instruction writes wait for the core to go idle
  assign hold = psel && pwrite && isInstr && busy;
  assign pready = !hold;

  // Only the instruction register is writable
  assign pslverr = access && (!mapped || (pwrite && !isInstr));

  assign start = access && pwrite && isInstr && !busy;

  always_ff @(posedge clk)
  begin
    if (reset)
      instr <= '0;
    else if (start)
      instr <= pwdata;
  end

  assign debugIndex = paddr[regIndexWidth+1:2];

  assign status = {flags, {(dataWidth-6){1'b0}}, illegal, busy};

  always_comb
  begin
    if (isStatus)
      prdata = status;
    else if (isInstr)
      prdata = instr;
    else if (isReg)
      prdata = debugData;
    else
      prdata = '0;
  end

endmodule

//--- source/coreTop.sv
`timescale 1ns/1ps

module coreTop
  import coreDefs::*;
#(
  parameter int apbAddrWidth = 8
)
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [apbAddrWidth-1:0] paddr,
  input  logic [dataWidth-1:0]    pwdata,
  output logic [dataWidth-1:0]    prdata,
  output logic                    pready,
  output logic                    pslverr
);

  logic [dataWidth-1:0]     instr;
  logic                     start;
  logic                     busy;
  logic                     illegal;
  logic [3:0]               flags;
  logic [regIndexWidth-1:0] debugIndex;
  logic [dataWidth-1:0]     debugData;
  aluOp                     op;
  logic                     carryIn;
  logic [regIndexWidth-1:0] readIndexN;
  logic [regIndexWidth-1:0] writeIndex;
  logic                     writeEnable;
  logic [dataWidth-1:0]     rnData;
  logic [dataWidth-1:0]     operand;
  logic [dataWidth-1:0]     result;
  logic [3:0]               aluFlags;

  apbHostPort #(
    .apbAddrWidth(apbAddrWidth)
  ) hostPort0 (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .busy(busy),
    .illegal(illegal),
    .flags(flags),
    .debugData(debugData),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .instr(instr),
    .start(start),
    .debugIndex(debugIndex)
  );

  microSequencer sequencer0 (
    .clk(clk),
    .reset(reset),
    .start(start),
    .instr(instr),
    .aluFlags(aluFlags),
    .busy(busy),
    .illegal(illegal),
    .flags(flags),
    .op(op),
    .carryIn(carryIn),
    .readIndexN(readIndexN),
    .writeIndex(writeIndex),
    .writeEnable(writeEnable)
  );

  registerFile registers0 (
    .clk(clk),
    .reset(reset),
    .writeEnable(writeEnable),
    .writeIndex(writeIndex),
    .readIndexN(readIndexN),
    .debugIndex(debugIndex),
    .writeData(result),
    .readDataN(rnData),
    .debugData(debugData)
  );

  immediateRotator rotator0 (
    .imm(instr[immHi:immLo]),
    .rotate(instr[rotHi:rotLo]),
    .operand(operand)
  );

  alu alu0 (
    .a(rnData),
    .b(operand),
    .op(op),
    .carryIn(carryIn),
    .result(result),
    .flagsOut(aluFlags)
  );

endmodule

//--- source/immediateRotator.sv
`timescale 1ns/1ps

module immediateRotator
  import coreDefs::*;
(
  input  logic [7:0]           imm,
  input  logic [3:0]           rotate,
  output logic [dataWidth-1:0] operand
);

  logic [dataWidth-1:0]   extended;
  logic [2*dataWidth-1:0] doubled;
  logic [2*dataWidth-1:0] shifted;
  logic [4:0]             amount;

  assign extended = {{(dataWidth-8){1'b0}}, imm};

  // Rotate right by twice the field
  assign amount = {rotate, 1'b0};

  // Shifting the doubled word wraps the low bits into the top
  assign doubled = {extended, extended};
  assign shifted = doubled >> amount;

  assign operand = shifted[dataWidth-1:0];

endmodule

//--- source/microSequencer.sv
`timescale 1ns/1ps

module microSequencer
  import coreDefs::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic [dataWidth-1:0]     instr,
  input  logic [3:0]               aluFlags,
  output logic                     busy,
  output logic                     illegal,
  output logic [3:0]               flags,
  output aluOp                     op,
  output logic                     carryIn,
  output logic [regIndexWidth-1:0] readIndexN,
  output logic [regIndexWidth-1:0] writeIndex,
  output logic                     writeEnable
);

  seqState state;
  seqState nextState;
  logic    isTest;
  logic    flagUpdate;

  always_comb
  begin
    nextState = state;
    case (state)
      idle:
      begin
        if (start)
          nextState = decode;
      end
      decode:    nextState = execute;
      execute:   nextState = writeBack;
      writeBack: nextState = idle;
      default:   nextState = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= idle;
    else
      state <= nextState;
  end

  // Class check result held until the next decode
  always_ff @(posedge clk)
  begin
    if (reset)
      illegal <= 1'b0;
    else if (state == decode)
      illegal <= (instr[classHi:classLo] != immClass);
  end

  assign op = aluOp'(instr[opHi:opLo]);
  assign isTest = op inside {opTst, opTeq, opCmp, opCmn};

  // Compare ops always set flags
  assign flagUpdate = (state == writeBack) && !illegal && (instr[setFlagsBit] || isTest);

  always_ff @(posedge clk)
  begin
    if (reset)
      flags <= 4'b0000;
    else if (flagUpdate)
      flags <= aluFlags;
  end

  assign carryIn = flags[1];
  assign readIndexN = instr[rnHi:rnLo];
  assign writeIndex = instr[rdHi:rdLo];

  // No destination write for compare ops
  assign writeEnable = (state == writeBack) && !illegal && !isTest;

  assign busy = (state != idle);

endmodule

//--- verification/coreChecker_checker.sv
`timescale 1ns/1ps

module coreChecker
  import coreDefs::*;
(
  input logic    clk,
  input logic    reset,
  input logic    start,
  input seqState state,
  input logic    busy,
  input logic    writeEnable
);

  int failCount = 0;

  // Start walks decode, execute, writeBack on consecutive cycles
  assert property (@(posedge clk) disable iff (reset) (state == idle && start) |=> state == decode)
  else
  begin
    failCount++;
    $error("start in idle did not lead to decode");
  end

  assert property (@(posedge clk) disable iff (reset) state == decode |=> state == execute)
  else
  begin
    failCount++;
    $error("decode not followed by execute");
  end

  assert property (@(posedge clk) disable iff (reset) state == execute |=> state == writeBack)
  else
  begin
    failCount++;
    $error("execute not followed by writeBack");
  end

  assert property (@(posedge clk) disable iff (reset) writeEnable |-> state == writeBack)
  else
  begin
    failCount++;
    $error("register write outside writeBack");
  end

  assert property (@(posedge clk) disable iff (reset) state == idle |-> !busy)
  else
  begin
    failCount++;
    $error("busy high while idle");
  end

endmodule

bind microSequencer coreChecker checker0 (
  .clk(clk),
  .reset(reset),
  .start(start),
  .state(state),
  .busy(busy),
  .writeEnable(writeEnable)
);

//--- verification/coreTb.sv
`timescale 1ns/1ps

module coreTb
  import coreDefs::*;
();

  localparam int apbAddrWidth = 8;
  localparam int instrCount = 437;
  localparam int cycleLimit = 40 * instrCount + 100;

  logic                    clk = 1'b0;
  logic                    reset;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [apbAddrWidth-1:0] paddr;
  logic [dataWidth-1:0]    pwdata;
  logic [dataWidth-1:0]    prdata;
  logic                    pready;
  logic                    pslverr;

  logic [dataWidth-1:0] modelRegs [regCount];
  logic [3:0]           modelFlags;
  logic                 modelIllegal;
  int                   cycleCount = 0;

  coreTop #(
    .apbAddrWidth(apbAddrWidth)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  function automatic logic [31:0] makeInstr(input logic [2:0] cls, input aluOp code,
                                            input logic s, input logic [3:0] rn,
                                            input logic [3:0] rd, input logic [3:0] rot,
                                            input logic [7:0] imm);
    return {4'hE, cls, code, s, rn, rd, rot, imm};
  endfunction

  // Bitwise rotate right by twice the rotate field
  function automatic logic [31:0] rotateImm(input logic [7:0] imm, input logic [3:0] rot);
    logic [31:0] x;
    x = {24'b0, imm};
    for (int i = 0; i < 2 * int'(rot); i++)
      x = {x[0], x[31:1]};
    return x;
  endfunction

  function automatic void refExecute(input logic [31:0] ins,
                                     input logic [31:0] regsIn [regCount],
                                     input logic [3:0] flagsIn, output logic bad,
                                     output logic writes, output logic [31:0] value,
                                     output logic [3:0] flagsNew);
    logic [31:0]        a;
    logic [31:0]        b;
    logic               cin;
    logic               c;
    logic               v;
    logic               isTest;
    logic               swap;
    logic               subtract;
    logic               extra;
    logic [63:0]        ux;
    logic [63:0]        uy;
    logic [63:0]        ures;
    logic signed [63:0] sx;
    logic signed [63:0] sy;
    logic signed [63:0] sres;
    aluOp               code;
    code = aluOp'(ins[opHi:opLo]);
    a = regsIn[ins[rnHi:rnLo]];
    b = rotateImm(ins[immHi:immLo], ins[rotHi:rotLo]);
    cin = flagsIn[1];
    c = cin;
    v = 1'b0;
    case (code)
      opAnd, opTst: value = a & b;
      opEor, opTeq: value = a ^ b;
      opOrr:        value = a | b;
      opMov:        value = b;
      opBic:        value = a & ~b;
      opMvn:        value = ~b;
      default:
      begin
        swap = code inside {opRsb, opRsc};
        subtract = code inside {opSub, opRsb, opCmp, opSbc, opRsc};
        extra = (code == opAdc) ? cin : ((code inside {opSbc, opRsc}) ? !cin : 1'b0);
        ux = swap ? {32'b0, b} : {32'b0, a};
        uy = swap ? {32'b0, a} : {32'b0, b};
        sx = {{32{ux[31]}}, ux[31:0]};
        sy = {{32{uy[31]}}, uy[31:0]};
        if (subtract)
        begin
          ures = ux - uy - 64'(extra);
          sres = sx - sy - $signed(64'(extra));
          c = !ures[63];
        end
        else
        begin
          ures = ux + uy + 64'(extra);
          sres = sx + sy + $signed(64'(extra));
          c = ures[32];
        end
        // Out of 32-bit signed range
        v = (sres != {{32{sres[31]}}, sres[31:0]});
        value = ures[31:0];
      end
    endcase
    isTest = code inside {opTst, opTeq, opCmp, opCmn};
    bad = (ins[classHi:classLo] != immClass);
    writes = !bad && !isTest;
    flagsNew = (!bad && (ins[setFlagsBit] || isTest)) ? {value[31], value == '0, c, v} : flagsIn;
  endfunction

  function automatic logic [apbAddrWidth-1:0] regOffset(input logic [3:0] k);
    return apbAddrWidth'(regBaseAddr + 32'(k) * 4);
  endfunction

  task automatic apbTransfer(input logic write, input logic [apbAddrWidth-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err, output int held);
    logic ready;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    held = 0;
    ready = 1'b0;
    while (!ready)
    begin
      @(negedge clk);
      ready = pready;
      rdata = prdata;
      err = pslverr;
      if (!ready)
        held++;
      @(posedge clk);
    end
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input logic [apbAddrWidth-1:0] addr, input logic [31:0] data,
                          output logic err, output int held);
    logic [31:0] unused;
    apbTransfer(1'b1, addr, data, unused, err, held);
  endtask

  task automatic apbRead(input logic [apbAddrWidth-1:0] addr, output logic [31:0] data,
                         output logic err);
    int held;
    apbTransfer(1'b0, addr, 32'b0, data, err, held);
  endtask

  task automatic readAndCheck(input logic [apbAddrWidth-1:0] addr,
                              input logic [31:0] expected, input string what);
    logic [31:0] data;
    logic        err;
    apbRead(addr, data, err);
    checkEqual(32'(err), 0, {what, " pslverr"});
    checkEqual(data, expected, what);
  endtask

  // Read access phase lands in the fourth cycle after the write
  task automatic checkStatus();
    @(posedge clk);
    readAndCheck(apbAddrWidth'(statusAddr), {modelFlags, 26'b0, modelIllegal, 1'b0}, "status");
  endtask

  task automatic checkResult(input logic [3:0] rd);
    checkStatus();
    readAndCheck(regOffset(rd), modelRegs[rd], $sformatf("destination r%0d", rd));
  endtask

  task automatic checkAllState();
    checkStatus();
    for (int k = 0; k < regCount; k++)
      readAndCheck(regOffset(4'(k)), modelRegs[k], $sformatf("register r%0d", k));
  endtask

  task automatic issueInstr(input logic [31:0] ins, output int held);
    logic        bad;
    logic        writes;
    logic [31:0] value;
    logic [3:0]  newFlags;
    logic        err;
    refExecute(ins, modelRegs, modelFlags, bad, writes, value, newFlags);
    apbWrite(apbAddrWidth'(instrAddr), ins, err, held);
    checkEqual(32'(err), 0, "pslverr on instruction write");
    if (writes)
      modelRegs[ins[rdHi:rdLo]] = value;
    modelFlags = newFlags;
    modelIllegal = bad;
  endtask

  initial
  begin
    int          waits;
    logic        err;
    logic [3:0]  rd;
    logic [31:0] data;
    void'($urandom(32'h9d9338f6));
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    foreach (modelRegs[k])
      modelRegs[k] = '0;
    modelFlags = 4'b0000;
    modelIllegal = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    checkAllState();

    // Every rotate amount with bits wrapping into the top byte
    for (int r = 0; r < 16; r++)
    begin
      issueInstr(makeInstr(immClass, opMov, 1'($urandom), 4'($urandom), 4'(r), 4'(r),
                           8'($urandom) | 8'h81), waits);
      checkResult(4'(r));
      issueInstr(makeInstr(immClass, opMvn, 1'($urandom), 4'($urandom), 4'(15 - r), 4'(r),
                           8'($urandom) | 8'h81), waits);
      checkResult(4'(15 - r));
    end

    for (int i = 0; i < 400; i++)
    begin
      rd = 4'($urandom);
      issueInstr(makeInstr(immClass, aluOp'(4'(i)), 1'($urandom), 4'($urandom), rd,
                           4'($urandom), 8'($urandom)), waits);
      checkResult(rd);
    end

    issueInstr(makeInstr(3'b000, opMov, 1'b1, 4'd1, 4'd5, 4'd0, 8'h5a), waits);
    checkAllState();
    issueInstr(makeInstr(3'b101, opAdd, 1'b1, 4'd2, 4'd6, 4'd3, 8'hc3), waits);
    checkAllState();
    issueInstr(makeInstr(immClass, opOrr, 1'b1, 4'd7, 4'd8, 4'd1, 8'h0f), waits);
    checkResult(4'd8);

    // Second write arrives while the first is still running
    issueInstr(makeInstr(immClass, opAdd, 1'b1, 4'd2, 4'd3, 4'd0, 8'h11), waits);
    issueInstr(makeInstr(immClass, opSub, 1'b1, 4'd3, 4'd4, 4'd0, 8'h22), waits);
    checkEqual(32'(waits > 0), 1, "back-to-back instruction write not held");
    checkResult(4'd3);
    checkResult(4'd4);

    apbWrite(apbAddrWidth'(statusAddr), 32'hffff_ffff, err, waits);
    checkEqual(32'(err), 1, "pslverr on status write");
    apbWrite(regOffset(4'd7), 32'h1234_5678, err, waits);
    checkEqual(32'(err), 1, "pslverr on register write");
    apbRead(8'h08, data, err);
    checkEqual(32'(err), 1, "pslverr on unmapped read");
    apbRead(8'h41, data, err);
    checkEqual(32'(err), 1, "pslverr on misaligned read");
    checkAllState();

    if (dut0.sequencer0.checker0.failCount == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("test failed");
      $fatal(1, "sequencer assertions failed");
    end
  end

endmodule

//--- verilog.f
common/coreDefs.sv
alu/alu.sv
registerFile/registerFile.sv
source/immediateRotator.sv
source/microSequencer.sv
source/apbHostPort.sv
source/coreTop.sv
verification/coreChecker_checker.sv
verification/coreTb.sv
